/* files.f */
verilog/acc_pkg.sv
verilog/acc_result_if.sv
verilog/acc_sram.sv
verilog/acc_cfg_regs.sv
verilog/psum_accumulator.sv
verilog/relu_maxpool.sv
verilog/acc_top.sv
testbench/tb_acc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the accumulator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_acc_top -o sim_acc_top

./obj_dir/sim_acc_top | tee sim.log

if grep -qF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/tb_acc_top.sv */
module tb_acc_top;
    import acc_pkg::*;

    typedef struct packed {
        int size;
        int ch;
        int shift;    // psum magnitude, 0 gives the full 16-bit range
        int gaps;     // chance of an input gap, in eighths
        bit mid_cfg;  // next row's shape is requested during this frame
    } frame_row_t;

    localparam int N_FRAMES = 7;
    localparam frame_row_t FRAMES [N_FRAMES] = '{
        '{4, 1, 8, 0, 1'b0},
        '{2, 3, 0, 2, 1'b0},   // saturates both ways
        '{6, 2, 9, 0, 1'b1},
        '{8, 4, 10, 3, 1'b0},
        '{30, 1, 4, 0, 1'b0},
        '{10, 5, 0, 1, 1'b1},
        '{4, 63, 11, 2, 1'b0}
    };

    logic  clk;
    logic  rst_n;
    logic  cfg_req_i;
    size_t cfg_ofmap_size_i;
    ch_t   cfg_ifmap_ch_i;
    logic  cfg_ack_o;
    psum_t psum_i;
    logic  psum_valid_i;
    logic  psum_ready_o;
    logic  pool_valid_o;
    act_t  pool_data_o;
    logic  pool_last_o;

    logic [31:0] lfsr_q = 32'he03c_6654;
    int    errors;
    int    timeouts;
    int    sent_cnt;
    bit    frame_done;
    bit    in_readout;   // last psum sent, pool_last_o not yet seen
    psum_t psum_q[$];
    act_t  exp_q[$];
    act_t  got_q[$];
    logic  last_q[$];

    acc_top acc_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_req_i        (cfg_req_i),
        .cfg_ofmap_size_i (cfg_ofmap_size_i),
        .cfg_ifmap_ch_i   (cfg_ifmap_ch_i),
        .cfg_ack_o        (cfg_ack_o),
        .psum_i           (psum_i),
        .psum_valid_i     (psum_valid_i),
        .psum_ready_o     (psum_ready_o),
        .pool_valid_o     (pool_valid_o),
        .pool_data_o      (pool_data_o),
        .pool_last_o      (pool_last_o)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    task automatic check_act(input string name, input act_t got, input act_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // psums in channel, row, column order and the pooled values they should give
    task automatic build_frame(input frame_row_t f);
        int sum [SRAM_DEPTH];
        logic signed [15:0] raw;
        int c, p, k, v, m, wr, wc;
        psum_q.delete();
        exp_q.delete();
        for (p = 0; p < f.size * f.size; p++) begin
            sum[p] = 0;
        end
        for (c = 0; c < f.ch; c++) begin
            for (p = 0; p < f.size * f.size; p++) begin
                raw = 16'(rand_bits(16));
                psum_q.push_back(psum_t'(raw >>> f.shift));
                sum[p] += int'(raw >>> f.shift);
            end
        end
        for (wr = 0; wr < f.size / 2; wr++) begin
            for (wc = 0; wc < f.size / 2; wc++) begin
                m = 0;
                for (k = 0; k < 4; k++) begin
                    v = sum[(2 * wr + k / 2) * f.size + 2 * wc + k % 2];
                    if (v > 127) v = 127;
                    if (v < -128) v = -128;
                    if (v < 0) v = 0;  // relu
                    if (v > m) m = v;
                end
                exp_q.push_back(act_t'(m));
            end
        end
    endtask

    task automatic send_frame(input int gaps);
        int i, t;
        @(posedge clk);
        #1;
        for (i = 0; i < psum_q.size(); i++) begin
            if (gaps != 0 && rand_bits(3) < gaps) begin
                repeat (1 + rand_bits(2)) begin
                    @(posedge clk);
                    #1;
                end
            end
            psum_i       = psum_q[i];
            psum_valid_i = 1'b1;
            t = 0;
            @(negedge clk);
            while (!psum_ready_o && t < 200) begin
                t++;
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            psum_valid_i = 1'b0;
            if (t >= 200) begin
                $display("timeout: psum_ready_o stayed low at psum %0d", i);
                timeouts++;
                break;
            end
            sent_cnt++;
        end
        in_readout = (timeouts == 0);
    endtask

    task automatic request_config(input int sz, input int ch, input bit mid_frame);
        int t;
        t = 0;
        while (mid_frame && sent_cnt < 3 && t < 1000) begin  // let the frame get going
            t++;
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        check_bit("cfg_ack_o", cfg_ack_o, 1'b0);
        cfg_ofmap_size_i = size_t'(sz);
        cfg_ifmap_ch_i   = ch_t'(ch);
        cfg_req_i        = 1'b1;
        t = 0;
        @(negedge clk);
        while (!cfg_ack_o && t < 40000) begin
            t++;
            @(negedge clk);
        end
        if (!cfg_ack_o) begin
            $display("timeout: no cfg_ack_o for size %0d, %0d channels", sz, ch);
            timeouts++;
            @(posedge clk);
            #1;
            cfg_req_i = 1'b0;
        end else begin
            if (mid_frame) check_bit("frame done at cfg_ack_o", frame_done, 1'b1);
            @(negedge clk);
            check_bit("cfg_ack_o", cfg_ack_o, 1'b1);
            @(posedge clk);
            #1;
            cfg_req_i = 1'b0;
            @(negedge clk);
            check_bit("cfg_ack_o", cfg_ack_o, 1'b1); // falls on the next edge
            @(negedge clk);
            check_bit("cfg_ack_o", cfg_ack_o, 1'b0);
        end
    endtask

    task automatic wait_frame_done();
        int t;
        t = 0;
        while (!frame_done && t < 5000) begin
            t++;
            @(negedge clk);
        end
        if (!frame_done) begin
            $display("timeout: frame ended without pool_last_o");
            timeouts++;
        end
    endtask

    task automatic compare_frame();
        int i;
        check_count("pooled outputs", got_q.size(), exp_q.size());
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_act("pool_data_o", got_q[i], exp_q[i]);
            check_bit("pool_last_o", last_q[i], logic'(i == exp_q.size() - 1));
        end
    endtask

    // pooled output collection
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_readout) check_bit("psum_ready_o", psum_ready_o, 1'b0);
            if (pool_valid_o) begin
                got_q.push_back(pool_data_o);
                last_q.push_back(pool_last_o);
                if (pool_last_o) begin
                    frame_done = 1'b1;
                    in_readout = 1'b0;
                end
            end else begin
                check_bit("pool_last_o", pool_last_o, 1'b0);
            end
        end
    end

    initial begin
        int r;
        bit preloaded;
        clk              = 1'b0;
        rst_n            = 1'b0;
        cfg_req_i        = 1'b0;
        cfg_ofmap_size_i = '0;
        cfg_ifmap_ch_i   = '0;
        psum_i           = '0;
        psum_valid_i     = 1'b0;
        errors           = 0;
        timeouts         = 0;
        sent_cnt         = 0;
        frame_done       = 1'b0;
        in_readout       = 1'b0;
        preloaded        = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin  // nothing configured yet
            @(negedge clk);
            check_bit("psum_ready_o", psum_ready_o, 1'b0);
            check_bit("cfg_ack_o", cfg_ack_o, 1'b0);
            check_bit("pool_valid_o", pool_valid_o, 1'b0);
        end

        for (r = 0; r < N_FRAMES; r++) begin
            if (!preloaded) request_config(FRAMES[r].size, FRAMES[r].ch, 1'b0);
            preloaded = 1'b0;
            build_frame(FRAMES[r]);
            frame_done = 1'b0;
            sent_cnt   = 0;
            got_q.delete();
            last_q.delete();
            if (FRAMES[r].mid_cfg) begin
                fork
                    send_frame(FRAMES[r].gaps);
                    request_config(FRAMES[r + 1].size, FRAMES[r + 1].ch, 1'b1);
                join
                preloaded = 1'b1;
            end else begin
                send_frame(FRAMES[r].gaps);
            end
            wait_frame_done();
            compare_frame();
            if (timeouts != 0) break;
        end

        $display("frames %0d, errors %0d, timeouts %0d", N_FRAMES, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/acc_cfg_regs.sv */
module acc_cfg_regs (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_req_i,
    input  acc_pkg::size_t cfg_ofmap_size_i,
    input  acc_pkg::ch_t   cfg_ifmap_ch_i,
    input  logic           frame_busy_i,
    output logic           cfg_ack_o,
    output acc_pkg::size_t ofmap_size_o,
    output acc_pkg::ch_t   ifmap_ch_o,
    output logic           cfg_valid_o
);
    import acc_pkg::*;

    logic accept;

    // new request, not yet acked, and no frame in flight
    assign accept = cfg_req_i && !cfg_ack_o && !frame_busy_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_ack_o   <= 1'b0;
            cfg_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                cfg_ack_o   <= 1'b1;
                cfg_valid_o <= 1'b1;
            end else if (!cfg_req_i) begin
                cfg_ack_o <= 1'b0; // phase 4
            end
        end
    end

    // shape registers
    always_ff @(posedge clk) begin
        if (accept) begin
            ofmap_size_o <= cfg_ofmap_size_i;
            ifmap_ch_o   <= cfg_ifmap_ch_i;
        end
    end

    // ack holds for as long as the host keeps req up
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ack_o && cfg_req_i |=> cfg_ack_o);

endmodule

/* verilog/acc_pkg.sv */
package acc_pkg;

    // datapath widths
    localparam int PSUM_W = 16;
    localparam int ACC_W  = 32;
    localparam int ACT_W  = 8;

    // accumulation memory
    localparam int SRAM_DEPTH = 1024;
    localparam int ADDR_W     = 10;

    // layer shape fields
    localparam int SIZE_W = 5;
    localparam int CH_W   = 6;

    typedef logic signed [PSUM_W-1:0] psum_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef logic signed [ACT_W-1:0] act_t;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [SIZE_W-1:0] size_t; // ofmap side, even, 2..30

    typedef logic [CH_W-1:0] ch_t;     // input channels, 1..63

endpackage

/* verilog/acc_result_if.sv */
interface acc_result_if;
    import acc_pkg::*;

    logic  res_valid;
    act_t  res_data;  // saturated accumulator word
    addr_t res_addr;  // address it was read from
    logic  res_last;

    modport src (
        output res_valid,
        output res_data,
        output res_addr,
        output res_last
    );

    modport dst (
        input res_valid,
        input res_data,
        input res_addr,
        input res_last
    );

endinterface

/* verilog/acc_sram.sv */
module acc_sram (
    input  logic           clk,
    input  logic           wr_en_i,
    input  logic           rd_en_i,
    input  acc_pkg::addr_t wr_addr_i,
    input  acc_pkg::addr_t rd_addr_i,
    input  acc_pkg::acc_t  wr_data_i,
    output acc_pkg::acc_t  rd_data_o
);
    import acc_pkg::*;

    acc_t mem [SRAM_DEPTH];

    // same-address read/write returns the old word
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* verilog/acc_top.sv */
module acc_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_req_i,
    input  acc_pkg::size_t cfg_ofmap_size_i,
    input  acc_pkg::ch_t   cfg_ifmap_ch_i,
    output logic           cfg_ack_o,
    input  acc_pkg::psum_t psum_i,
    input  logic           psum_valid_i,
    output logic           psum_ready_o,
    output logic           pool_valid_o,
    output acc_pkg::act_t  pool_data_o,
    output logic           pool_last_o
);
    import acc_pkg::*;

    size_t ofmap_size;
    ch_t   ifmap_ch;
    logic  cfg_valid;
    logic  frame_busy;

    acc_result_if res_if ();

    acc_cfg_regs acc_cfg_regs_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_req_i        (cfg_req_i),
        .cfg_ofmap_size_i (cfg_ofmap_size_i),
        .cfg_ifmap_ch_i   (cfg_ifmap_ch_i),
        .frame_busy_i     (frame_busy),
        .cfg_ack_o        (cfg_ack_o),
        .ofmap_size_o     (ofmap_size),
        .ifmap_ch_o       (ifmap_ch),
        .cfg_valid_o      (cfg_valid)
    );

    psum_accumulator psum_accumulator_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_i       (psum_i),
        .psum_valid_i (psum_valid_i),
        .psum_ready_o (psum_ready_o),
        .ofmap_size_i (ofmap_size),
        .ifmap_ch_i   (ifmap_ch),
        .cfg_valid_i  (cfg_valid),
        .frame_busy_o (frame_busy),
        .res          (res_if.src)
    );

    relu_maxpool relu_maxpool_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res_if.dst),
        .pool_valid_o (pool_valid_o),
        .pool_data_o  (pool_data_o),
        .pool_last_o  (pool_last_o)
    );

endmodule

/* verilog/psum_accumulator.sv */
module psum_accumulator (
    input  logic           clk,
    input  logic           rst_n,
    input  acc_pkg::psum_t psum_i,
    input  logic           psum_valid_i,
    output logic           psum_ready_o,
    input  acc_pkg::size_t ofmap_size_i,
    input  acc_pkg::ch_t   ifmap_ch_i,
    input  logic           cfg_valid_i,
    output logic           frame_busy_o,
    acc_result_if.src      res
);
    import acc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ACC,
        S_FINAL,
        S_POOL,
        S_LAST
    } state_t;

    state_t     state, state_n;
    size_t      col, col_n;
    size_t      row, row_n;
    ch_t        ch, ch_n;
    addr_t      acc_addr, acc_addr_n;
    size_t      win_col, win_col_n;
    size_t      win_row, win_row_n;
    logic [1:0] sub, sub_n;       // position inside the 2x2 window
    addr_t      pool1, pool1_n;   // top-left word of the window
    logic       tail_q;

    logic       accept;
    logic       last_win;
    size_t      size_m1;
    size_t      half_m1;
    ch_t        ch_m1;
    addr_t      size_a;
    addr_t      pool_addr;

    logic       s1_valid;
    logic       s1_first;
    psum_t      s1_psum;
    addr_t      s1_addr;
    logic       s2_valid;
    acc_t       s2_sum;
    addr_t      s2_addr;
    acc_t       acc_in;

    logic       rd_en;
    addr_t      rd_addr;
    acc_t       rd_data;
    logic       rd_last;
    logic       rd_pool_q;
    logic       rd_last_q;
    addr_t      rd_addr_q;
    act_t       sat_data;

    assign size_m1 = ofmap_size_i - size_t'(1);
    assign half_m1 = (ofmap_size_i >> 1) - size_t'(1);
    assign ch_m1   = ifmap_ch_i - ch_t'(1);
    assign size_a  = addr_t'(ofmap_size_i);

    // input closes from the last psum until the pooled tail has left
    assign psum_ready_o = cfg_valid_i && ((state == S_IDLE && !tail_q) || state == S_ACC);
    assign accept       = psum_valid_i && psum_ready_o;
    assign frame_busy_o = (state != S_IDLE) || tail_q || accept;

    assign last_win = (win_col == half_m1) && (win_row == half_m1);

    always_comb begin
        case (sub)
            2'd0:    pool_addr = pool1;
            2'd1:    pool_addr = pool1 + addr_t'(1);
            2'd2:    pool_addr = pool1 + size_a;
            default: pool_addr = pool1 + size_a + addr_t'(1);
        endcase
    end

    always_comb begin
        state_n    = state;
        col_n      = col;
        row_n      = row;
        ch_n       = ch;
        acc_addr_n = acc_addr;
        win_col_n  = win_col;
        win_row_n  = win_row;
        sub_n      = sub;
        pool1_n    = pool1;
        rd_en      = 1'b0;
        rd_addr    = acc_addr;
        rd_last    = 1'b0;

        case (state)
            S_IDLE, S_ACC: begin
                if (accept) begin
                    rd_en   = 1'b1; // fetch the running sum
                    state_n = S_ACC;
                    if (col == size_m1) begin
                        col_n = '0;
                        if (row == size_m1) begin
                            row_n      = '0;
                            acc_addr_n = '0;
                            if (ch == ch_m1) begin
                                ch_n    = '0;
                                state_n = S_FINAL;
                            end else begin
                                ch_n = ch + ch_t'(1);
                            end
                        end else begin
                            row_n      = row + size_t'(1);
                            acc_addr_n = acc_addr + addr_t'(1);
                        end
                    end else begin
                        col_n      = col + size_t'(1);
                        acc_addr_n = acc_addr + addr_t'(1);
                    end
                end
            end
            S_FINAL: begin
                win_col_n = '0;
                win_row_n = '0;
                sub_n     = '0;
                pool1_n   = '0;
                // last write is in stage 2 now, reads start after it
                if (!s1_valid) begin
                    state_n = S_POOL;
                end
            end
            S_POOL: begin
                rd_en   = 1'b1;
                rd_addr = pool_addr;
                sub_n   = sub + 2'd1;
                if (sub == 2'd3) begin
                    if (win_col == half_m1) begin
                        win_col_n = '0;
                        win_row_n = win_row + size_t'(1);
                        pool1_n   = pool1 + size_a + addr_t'(2); // skip the odd row
                    end else begin
                        win_col_n = win_col + size_t'(1);
                        pool1_n   = pool1 + addr_t'(2);
                    end
                    if (last_win) begin
                        rd_last = 1'b1;
                        state_n = S_LAST;
                    end
                end
            end
            S_LAST: begin
                state_n = S_IDLE;
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            col       <= '0;
            row       <= '0;
            ch        <= '0;
            acc_addr  <= '0;
            win_col   <= '0;
            win_row   <= '0;
            sub       <= '0;
            pool1     <= '0;
            tail_q    <= 1'b0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rd_pool_q <= 1'b0;
            rd_last_q <= 1'b0;
        end else begin
            state     <= state_n;
            col       <= col_n;
            row       <= row_n;
            ch        <= ch_n;
            acc_addr  <= acc_addr_n;
            win_col   <= win_col_n;
            win_row   <= win_row_n;
            sub       <= sub_n;
            pool1     <= pool1_n;
            tail_q    <= (state == S_LAST); // covers the pooled output cycle
            s1_valid  <= accept;
            s2_valid  <= s1_valid;
            rd_pool_q <= (state == S_POOL);
            rd_last_q <= rd_last;
        end
    end

    // channel 0 starts from zero, sram holds the previous frame
    assign acc_in = s1_first ? acc_t'(0) : rd_data;

    always_ff @(posedge clk) begin
        s1_psum   <= psum_i;
        s1_addr   <= acc_addr;
        s1_first  <= (ch == '0);
        s2_sum    <= acc_in + acc_t'(s1_psum); // sign-extending cast
        s2_addr   <= s1_addr;
        rd_addr_q <= rd_addr;
    end

    acc_sram acc_sram_i (
        .clk       (clk),
        .wr_en_i   (s2_valid),
        .rd_en_i   (rd_en),
        .wr_addr_i (s2_addr),
        .rd_addr_i (rd_addr),
        .wr_data_i (s2_sum),
        .rd_data_o (rd_data)
    );

    // clamp to int8
    always_comb begin
        if (rd_data > acc_t'(127)) begin
            sat_data = act_t'(127);
        end else if (rd_data < acc_t'(-128)) begin
            sat_data = act_t'(-128);
        end else begin
            sat_data = act_t'(rd_data);
        end
    end

    assign res.res_valid = rd_pool_q;
    assign res.res_data  = sat_data;
    assign res.res_addr  = rd_addr_q;
    assign res.res_last  = rd_last_q;

    assert property (@(posedge clk) disable iff (!rst_n)
        res.res_valid |-> (state == S_POOL || state == S_LAST));

    // no new psums and no write-back while the frame is being read out
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_busy_o && (state == S_POOL || state == S_LAST) |-> !psum_ready_o && !s2_valid);

endmodule

/* verilog/relu_maxpool.sv */
module relu_maxpool (
    input  logic          clk,
    input  logic          rst_n,
    acc_result_if.dst     res,
    output logic          pool_valid_o,
    output acc_pkg::act_t pool_data_o,
    output logic          pool_last_o
);
    import acc_pkg::*;

    logic [1:0] cnt;      // values seen in this window
    act_t       relu_val;
    act_t       run_max;
    act_t       new_max;
    addr_t      grp_addr;

    assign relu_val = res.res_data[ACT_W-1] ? act_t'(0) : res.res_data;
    assign new_max  = (cnt == 2'd0 || relu_val > run_max) ? relu_val : run_max;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt          <= 2'd0;
            pool_valid_o <= 1'b0;
            pool_last_o  <= 1'b0;
        end else begin
            pool_valid_o <= 1'b0;
            pool_last_o  <= 1'b0;
            if (res.res_valid) begin
                cnt <= cnt + 2'd1;
                if (cnt == 2'd3) begin
                    pool_valid_o <= 1'b1;
                    pool_last_o  <= res.res_last;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.res_valid) begin
            run_max <= new_max;
            if (cnt == 2'd0) begin
                grp_addr <= res.res_addr;
            end
            if (cnt == 2'd3) begin
                pool_data_o <= new_max;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        res.res_valid && res.res_last |-> cnt == 2'd3);

    // window order from the accumulator: second word sits right of the first
    assert property (@(posedge clk) disable iff (!rst_n)
        res.res_valid && cnt == 2'd1 |-> res.res_addr == grp_addr + addr_t'(1));

endmodule
